/* files.f */
src/dbus_pkg.sv
src/axi_pkg.sv
src/dbus_front.sv
src/uncached_axi_master.sv
src/axi_scratch_ram.sv
src/uncached_dbus_top.sv
verification/uncached_dbus_assert.sv
verification/uncached_dbus_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -f files.f \
	--top-module uncached_dbus_tb -o uncached_dbus_sim

status=0
out=$(./obj_dir/uncached_dbus_sim +verilator+error+limit+1000) || status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
	exit "$status"
fi
echo "$out" | grep -qx "PASS: all tests"

/* src/axi_pkg.sv */
`default_nettype none

package axi_pkg;

	// Transaction ID width used on every AXI channel
	localparam int ID_WIDTH = 4;

	typedef logic [ID_WIDTH-1:0] axi_id_t;

	// Burst type encoding
	typedef logic [1:0] burst_t;

	localparam burst_t BURST_INCR = 2'b01;

	// Burst length is beats minus one
	typedef logic [3:0] len_t;

	localparam len_t LEN_SINGLE = 4'd0;

	// Beat size as log2 of the byte count
	typedef logic [2:0] size_t;

	// 4 bytes per beat
	localparam size_t SIZE_WORD = 3'b010;

	// Write strobes, one bit per byte lane
	typedef logic [3:0] strb_t;

	localparam strb_t STRB_ALL = 4'b1111;

endpackage

`default_nettype wire

/* src/axi_scratch_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_scratch_ram #(
	parameter int RAM_WORDS   = 64,
	parameter int ACCEPT_WAIT = 2,
	parameter int RESP_WAIT   = 3,
	parameter int BUS_WIDTH   = 4
) (
	input  wire logic                 clk,
	input  wire logic                 rst,
	// Read address
	input  wire logic                 arvalid,
	output logic                      arready,
	input  dbus_pkg::addr_t           araddr,
	input  wire logic [BUS_WIDTH-1:0] arid,
	input  axi_pkg::burst_t           arburst,
	input  axi_pkg::len_t             arlen,
	input  axi_pkg::size_t            arsize,
	// Read data
	output logic                      rvalid,
	input  wire logic                 rready,
	output dbus_pkg::word_t           rdata,
	output logic [BUS_WIDTH-1:0]      rid,
	// Write address
	input  wire logic                 awvalid,
	output logic                      awready,
	input  dbus_pkg::addr_t           awaddr,
	input  wire logic [BUS_WIDTH-1:0] awid,
	input  axi_pkg::burst_t           awburst,
	input  axi_pkg::len_t             awlen,
	input  axi_pkg::size_t            awsize,
	// Write data
	input  wire logic                 wvalid,
	output logic                      wready,
	input  dbus_pkg::word_t           wdata,
	input  axi_pkg::strb_t            wstrb,
	input  wire logic                 wlast,
	input  wire logic [BUS_WIDTH-1:0] wid,
	// Write response
	output logic                      bvalid,
	input  wire logic                 bready,
	output logic [BUS_WIDTH-1:0]      bid
);

localparam int MAX_WAIT   = (ACCEPT_WAIT > RESP_WAIT) ? ACCEPT_WAIT : RESP_WAIT;
localparam int CNT_W      = $clog2(MAX_WAIT + 2);
localparam int IDX_W      = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
localparam int WORD_SHIFT = $clog2(dbus_pkg::WORD_BYTES);

typedef enum logic [2:0] {
	IDLE,
	READ_WAIT,
	READ_RESP,
	WRITE_DATA,
	WRITE_RESP
} state_t;

state_t               state, state_d;
dbus_pkg::word_t      mem [RAM_WORDS];
dbus_pkg::word_t      rdata_q;
logic [CNT_W-1:0]     cnt, cnt_d;
logic                 acc_done;
logic                 resp_done;
logic                 ar_hs, aw_hs, w_hs;
logic                 ar_ok, aw_ok;
logic                 wr_ok;
logic [IDX_W-1:0]     wr_idx;
logic [BUS_WIDTH-1:0] rid_q, bid_q;

// Word index, upper address bits alias
function automatic logic [IDX_W-1:0] word_index(input dbus_pkg::addr_t addr);
	return IDX_W'((addr >> WORD_SHIFT) % RAM_WORDS);
endfunction

assign acc_done  = (cnt == CNT_W'(ACCEPT_WAIT));
assign resp_done = (cnt == CNT_W'(RESP_WAIT));

// Only single full-word INCR beats touch the memory
assign ar_ok = (arburst == axi_pkg::BURST_INCR) && (arlen == axi_pkg::LEN_SINGLE) &&
	(arsize == axi_pkg::SIZE_WORD);
assign aw_ok = (awburst == axi_pkg::BURST_INCR) && (awlen == axi_pkg::LEN_SINGLE) &&
	(awsize == axi_pkg::SIZE_WORD);

// Reads win when both address channels are waiting
assign arready = (state == IDLE) && acc_done;
assign awready = (state == IDLE) && acc_done && !arvalid;
assign wready  = (state == WRITE_DATA) && acc_done && (wid == bid_q);

assign ar_hs = arvalid && arready;
assign aw_hs = awvalid && awready;
assign w_hs  = wvalid && wready;

always_comb begin
	state_d = state;
	cnt_d   = cnt;
	case (state)
		IDLE: begin
			if (ar_hs) begin
				state_d = (RESP_WAIT == 0) ? READ_RESP : READ_WAIT;
				cnt_d   = CNT_W'(1);
			end else if (aw_hs) begin
				state_d = WRITE_DATA;
				cnt_d   = '0;
			end else if ((arvalid || awvalid) && !acc_done) begin
				cnt_d = cnt + CNT_W'(1);
			end
		end
		READ_WAIT: begin
			if (resp_done) begin
				state_d = READ_RESP;
				cnt_d   = '0;
			end else begin
				cnt_d = cnt + CNT_W'(1);
			end
		end
		READ_RESP: begin
			if (rready) state_d = IDLE;
		end
		WRITE_DATA: begin
			if (w_hs) begin
				state_d = wlast ? WRITE_RESP : WRITE_DATA;
				cnt_d   = '0;
			end else if (wvalid && !acc_done) begin
				cnt_d = cnt + CNT_W'(1);
			end
		end
		WRITE_RESP: begin
			if (bready) state_d = IDLE;
		end
		default: begin
			state_d = IDLE;
			cnt_d   = '0;
		end
	endcase
end

always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		state <= IDLE;
		cnt   <= '0;
		rid_q <= '0;
		bid_q <= '0;
		wr_ok <= 1'b0;
	end else begin
		state <= state_d;
		cnt   <= cnt_d;
		if (ar_hs) rid_q <= arid;
		if (aw_hs) begin
			bid_q <= awid;
			wr_ok <= aw_ok;
		end
	end
end

// Read word is fetched at address acceptance
always_ff @(posedge clk) begin
	if (ar_hs) rdata_q <= ar_ok ? mem[word_index(araddr)] : '0;
	if (aw_hs) wr_idx <= word_index(awaddr);
end

always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		for (int i = 0; i < RAM_WORDS; i++) begin
			mem[i] <= '0;
		end
	end else if (w_hs && wr_ok) begin
		for (int b = 0; b < dbus_pkg::WORD_BYTES; b++) begin
			if (wstrb[b]) mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
		end
	end
end

assign rvalid = (state == READ_RESP);
assign rdata  = rdata_q;
assign rid    = rid_q;
assign bvalid = (state == WRITE_RESP);
assign bid    = bid_q;

endmodule

`default_nettype wire

/* src/dbus_front.sv */
`timescale 1ns/1ps
`default_nettype none

module dbus_front (
	input  wire logic            clk,
	input  wire logic            rst,
	// CPU data bus
	input  wire logic            read,
	input  wire logic            write,
	input  dbus_pkg::addr_t      address,
	input  dbus_pkg::word_t      wrdata,
	output logic                 stall,
	output dbus_pkg::word_t      rddata,
	// Towards the AXI master
	output logic                 req_read,
	output logic                 req_write,
	output dbus_pkg::addr_t      req_addr,
	output dbus_pkg::word_t      req_wdata,
	input  wire logic            busy,
	input  wire logic            done_valid,
	input  dbus_pkg::word_t      done_data
);

dbus_pkg::word_t rddata_q;

// Master busy already looks one state ahead
assign stall = busy;

always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		req_read  <= 1'b0;
		req_write <= 1'b0;
	end else if (!stall) begin
		req_read  <= read;
		req_write <= write;
	end
end

always_ff @(posedge clk) begin
	if (!stall) begin
		req_addr  <= address;
		req_wdata <= wrdata;
	end
end

// Last completed word, held until the next completion
always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		rddata_q <= '0;
	end else if (done_valid) begin
		rddata_q <= done_data;
	end
end

// Forward the word in the cycle stall drops
assign rddata = done_valid ? done_data : rddata_q;

endmodule

`default_nettype wire

/* src/dbus_pkg.sv */
`default_nettype none

package dbus_pkg;

	// CPU data bus widths
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;

	// Bytes per data word, also the byte lanes of a write
	localparam int WORD_BYTES = DATA_WIDTH / 8;

	// Byte address as issued by the CPU
	typedef logic [ADDR_WIDTH-1:0] addr_t;

	// One data word, read or written
	typedef logic [DATA_WIDTH-1:0] word_t;

endpackage

`default_nettype wire

/* src/uncached_axi_master.sv */
`timescale 1ns/1ps
`default_nettype none

module uncached_axi_master #(
	parameter int BUS_WIDTH = 4
) (
	input  wire logic                 clk,
	input  wire logic                 rst,
	// Captured request from the front stage
	input  wire logic                 req_read,
	input  wire logic                 req_write,
	input  dbus_pkg::addr_t           req_addr,
	input  dbus_pkg::word_t           req_wdata,
	output logic                      busy,
	output logic                      done_valid,
	output dbus_pkg::word_t           done_data,
	// Read address
	output logic                      arvalid,
	input  wire logic                 arready,
	output dbus_pkg::addr_t           araddr,
	output logic [BUS_WIDTH-1:0]      arid,
	output axi_pkg::burst_t           arburst,
	output axi_pkg::len_t             arlen,
	output axi_pkg::size_t            arsize,
	// Read data
	input  wire logic                 rvalid,
	output logic                      rready,
	input  dbus_pkg::word_t           rdata,
	input  wire logic [BUS_WIDTH-1:0] rid,
	// Write address
	output logic                      awvalid,
	input  wire logic                 awready,
	output dbus_pkg::addr_t           awaddr,
	output logic [BUS_WIDTH-1:0]      awid,
	output axi_pkg::burst_t           awburst,
	output axi_pkg::len_t             awlen,
	output axi_pkg::size_t            awsize,
	// Write data
	output logic                      wvalid,
	input  wire logic                 wready,
	output dbus_pkg::word_t           wdata,
	output axi_pkg::strb_t            wstrb,
	output logic                      wlast,
	output logic [BUS_WIDTH-1:0]      wid,
	// Write response
	input  wire logic                 bvalid,
	output logic                      bready,
	input  wire logic [BUS_WIDTH-1:0] bid
);

typedef enum logic [2:0] {
	IDLE,
	READ_ADDR,
	READ_DATA,
	WRITE_ADDR,
	WRITE_DATA,
	FINISHED
} state_t;

// Every transaction goes out with ID zero
localparam axi_pkg::axi_id_t TXN_ID = '0;
localparam logic [BUS_WIDTH-1:0] BUS_ID = BUS_WIDTH'(TXN_ID);

state_t state, state_d;
logic   was_write;
logic   r_take;
logic   b_take;

// Beats or responses carrying another ID are not ours
assign r_take = rvalid && (rid == BUS_ID);
assign b_take = bvalid && (bid == BUS_ID);

always_comb begin
	state_d = state;
	case (state)
		IDLE: begin
			if (req_read) begin
				state_d = READ_ADDR;
			end else if (req_write) begin
				state_d = WRITE_ADDR;
			end
		end
		READ_ADDR: begin
			if (arready) state_d = READ_DATA;
		end
		READ_DATA: begin
			if (r_take) state_d = FINISHED;
		end
		WRITE_ADDR: begin
			if (awready) state_d = WRITE_DATA;
		end
		WRITE_DATA: begin
			if (wready) state_d = FINISHED;
		end
		FINISHED: begin
			// A write also retires its response here
			if (!was_write || b_take) state_d = IDLE;
		end
		default: begin
			state_d = IDLE;
		end
	endcase
end

always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		state     <= IDLE;
		was_write <= 1'b0;
	end else begin
		state <= state_d;
		if (state == IDLE && state_d == READ_ADDR) begin
			was_write <= 1'b0;
		end else if (state == IDLE && state_d == WRITE_ADDR) begin
			was_write <= 1'b1;
		end
	end
end

// Word handed back to the CPU side
always_ff @(posedge clk) begin
	if (state == READ_DATA && r_take) begin
		done_data <= rdata;
	end else if (state == WRITE_DATA && wready) begin
		done_data <= req_wdata;
	end
end

assign busy       = (state_d != IDLE);
assign done_valid = (state == FINISHED) && (state_d == IDLE);

// Single INCR beat of one full word
assign arvalid = (state == READ_ADDR);
assign araddr  = req_addr;
assign arid    = BUS_ID;
assign arburst = axi_pkg::BURST_INCR;
assign arlen   = axi_pkg::LEN_SINGLE;
assign arsize  = axi_pkg::SIZE_WORD;
assign rready  = (state == READ_DATA);

assign awvalid = (state == WRITE_ADDR);
assign awaddr  = req_addr;
assign awid    = BUS_ID;
assign awburst = axi_pkg::BURST_INCR;
assign awlen   = axi_pkg::LEN_SINGLE;
assign awsize  = axi_pkg::SIZE_WORD;

assign wvalid = (state == WRITE_DATA);
assign wdata  = req_wdata;
assign wstrb  = axi_pkg::STRB_ALL;
assign wlast  = 1'b1;
assign wid    = BUS_ID;

// bresp is not looked at
assign bready = 1'b1;

endmodule

`default_nettype wire

/* src/uncached_dbus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uncached_dbus_top #(
	parameter int RAM_WORDS   = 64,
	parameter int ACCEPT_WAIT = 2,
	parameter int RESP_WAIT   = 3,
	parameter int BUS_WIDTH   = axi_pkg::ID_WIDTH
) (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       read,
	input  wire logic       write,
	input  dbus_pkg::addr_t address,
	input  dbus_pkg::word_t wrdata,
	output logic            stall,
	output dbus_pkg::word_t rddata
);

// Front stage to master
logic            req_read;
logic            req_write;
dbus_pkg::addr_t req_addr;
dbus_pkg::word_t req_wdata;
logic            busy;
logic            done_valid;
dbus_pkg::word_t done_data;

// AXI read channels
logic                 arvalid, arready;
dbus_pkg::addr_t      araddr;
logic [BUS_WIDTH-1:0] arid;
axi_pkg::burst_t      arburst;
axi_pkg::len_t        arlen;
axi_pkg::size_t       arsize;
logic                 rvalid, rready;
dbus_pkg::word_t      rdata;
logic [BUS_WIDTH-1:0] rid;

// AXI write channels
logic                 awvalid, awready;
dbus_pkg::addr_t      awaddr;
logic [BUS_WIDTH-1:0] awid;
axi_pkg::burst_t      awburst;
axi_pkg::len_t        awlen;
axi_pkg::size_t       awsize;
logic                 wvalid, wready;
dbus_pkg::word_t      wdata;
axi_pkg::strb_t       wstrb;
logic                 wlast;
logic [BUS_WIDTH-1:0] wid;
logic                 bvalid, bready;
logic [BUS_WIDTH-1:0] bid;

// Port names match the nets above
dbus_front dbus_front_i (.*);

uncached_axi_master #(
	.BUS_WIDTH (BUS_WIDTH)
) uncached_axi_master_i (.*);

axi_scratch_ram #(
	.RAM_WORDS   (RAM_WORDS),
	.ACCEPT_WAIT (ACCEPT_WAIT),
	.RESP_WAIT   (RESP_WAIT),
	.BUS_WIDTH   (BUS_WIDTH)
) axi_scratch_ram_i (.*);

endmodule

`default_nettype wire

/* verification/uncached_dbus_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module uncached_dbus_assert (
	input wire logic clk,
	input wire logic rst,
	input wire logic arvalid,
	input wire logic arready,
	input wire logic awvalid,
	input wire logic awready,
	input wire logic wvalid,
	input wire logic wready
);

int unsigned fail_count = 0;
logic        aw_done;

// Write address accepted, data beat still to come
always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		aw_done <= 1'b0;
	end else if (awvalid && awready) begin
		aw_done <= 1'b1;
	end else if (wvalid && wready) begin
		aw_done <= 1'b0;
	end
end

assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
	else begin
		fail_count++;
		$error("arvalid dropped before arready");
	end

assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
	else begin
		fail_count++;
		$error("awvalid dropped before awready");
	end

assert property (@(posedge clk) disable iff (rst) wvalid && !wready |=> wvalid)
	else begin
		fail_count++;
		$error("wvalid dropped before wready");
	end

// Data only after its address
assert property (@(posedge clk) disable iff (rst) wvalid |-> aw_done)
	else begin
		fail_count++;
		$error("wvalid raised before the write address handshake");
	end

assert property (@(posedge clk) disable iff (rst) !(arvalid && awvalid))
	else begin
		fail_count++;
		$error("arvalid and awvalid were high together");
	end

endmodule

bind uncached_dbus_top uncached_dbus_assert uncached_dbus_assert_i (
	.clk     (clk),
	.rst     (rst),
	.arvalid (arvalid),
	.arready (arready),
	.awvalid (awvalid),
	.awready (awready),
	.wvalid  (wvalid),
	.wready  (wready)
);

`default_nettype wire

/* verification/uncached_dbus_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module uncached_dbus_tb;

localparam int RAM_WORDS  = 64;
localparam int TIMEOUT    = 200;
localparam int RANDOM_OPS = 200;

logic            clk;
logic            rst;
logic            read;
logic            write;
dbus_pkg::addr_t address;
dbus_pkg::word_t wrdata;
logic            stall;
dbus_pkg::word_t rddata;

// Reference copy of the scratch RAM
dbus_pkg::word_t ref_mem [RAM_WORDS];
dbus_pkg::word_t exp_data;
string           test_name;
logic            check_en;
bit              aborted;
// Request in flight whose result is still to be checked
bit              pend_valid;
dbus_pkg::word_t pend_exp;
string           pend_name;
int              checks = 0;
int              errors = 0;
int              timeouts = 0;
int              proto_errors;
integer          seed;

uncached_dbus_top uncached_dbus_top_i (
	.clk     (clk),
	.rst     (rst),
	.read    (read),
	.write   (write),
	.address (address),
	.wrdata  (wrdata),
	.stall   (stall),
	.rddata  (rddata)
);

always #20 clk = ~clk;

// Armed from one negedge to the next, so sampled at a quiet posedge
assert property (@(posedge clk) check_en |-> rddata == exp_data)
	else begin
		errors++;
		$display("error %s: expected %h, actual %h", test_name, exp_data, $sampled(rddata));
	end

assert property (@(posedge clk) check_en |-> !stall)
	else begin
		errors++;
		$display("Stall was high while the result of %s was checked", test_name);
	end

// RAM word slot, upper address bits alias
function automatic int word_slot(input dbus_pkg::addr_t addr);
	return int'((addr >> 2) % RAM_WORDS);
endfunction

task automatic arm_check(input dbus_pkg::word_t expected, input string name);
	exp_data  = expected;
	test_name = name;
	check_en  = 1'b1;
	checks++;
	@(negedge clk);
	check_en = 1'b0;
endtask

// Returns at the negedge where stall is low
task automatic wait_stall_low(input string name);
	int cycles;
	cycles = 0;
	@(negedge clk);
	while (stall && cycles < TIMEOUT) begin
		cycles++;
		@(negedge clk);
	end
	if (stall) begin
		timeouts++;
		aborted = 1'b1;
		$display("Stall did not fall within %0d cycles in test %s", TIMEOUT, name);
	end
endtask

// Request is held through stall, so it is taken in the first cycle stall is low
task automatic do_request(input logic is_write, input dbus_pkg::addr_t addr,
		input dbus_pkg::word_t data, input dbus_pkg::word_t expected, input string name);
	if (!aborted) begin
		@(posedge clk);
		read    <= !is_write;
		write   <= is_write;
		address <= addr;
		wrdata  <= data;
		wait_stall_low(pend_valid ? pend_name : name);
		if (!aborted) begin
			// Previous result is on rddata while this request is captured
			if (pend_valid) begin
				arm_check(pend_exp, pend_name);
			end
			pend_valid = 1'b1;
			pend_exp   = expected;
			pend_name  = name;
		end
	end
endtask

// Lets the last request complete and checks its result
task automatic finish_last_request();
	if (!aborted && pend_valid) begin
		@(posedge clk);
		read  <= 1'b0;
		write <= 1'b0;
		wait_stall_low(pend_name);
		if (!aborted) begin
			arm_check(pend_exp, pend_name);
		end
		pend_valid = 1'b0;
	end
endtask

task automatic write_word(input dbus_pkg::addr_t addr, input dbus_pkg::word_t data,
		input string name);
	ref_mem[word_slot(addr)] = data;
	// After a write rddata shows the written word
	do_request(1'b1, addr, data, data, name);
endtask

task automatic read_word(input dbus_pkg::addr_t addr, input string name);
	do_request(1'b0, addr, '0, ref_mem[word_slot(addr)], name);
endtask

initial begin
	int              i;
	int              kind;
	dbus_pkg::addr_t addr;
	dbus_pkg::word_t data;
	clk        = 1'b0;
	rst        = 1'b1;
	read       = 1'b0;
	write      = 1'b0;
	address    = '0;
	wrdata     = '0;
	check_en   = 1'b0;
	exp_data   = '0;
	test_name  = "";
	aborted    = 1'b0;
	pend_valid = 1'b0;
	pend_exp   = '0;
	pend_name  = "";
	seed       = 32'heee;
	for (i = 0; i < RAM_WORDS; i++) begin
		ref_mem[i] = '0;
	end

	repeat (2) @(posedge clk);
	rst <= 1'b0;
	@(negedge clk);
	arm_check('0, "reset");

	write_word(32'h0000_0010, 32'hcafe_0123, "write_data");
	read_word(32'h0000_0010, "write_read");

	// Memory is zero after reset
	do_request(1'b0, 32'h0000_0080, '0, '0, "unwritten_read");

	write_word(32'h0000_0024, 32'h5a5a_a5a5, "alias_write");
	read_word(dbus_pkg::addr_t'(32'h24 + RAM_WORDS * 4), "alias_read");

	// Word addresses span four aliases of the RAM
	for (i = 0; i < RANDOM_OPS; i++) begin
		kind = $random(seed);
		addr = dbus_pkg::addr_t'({$random(seed)} % (RAM_WORDS * 4)) << 2;
		data = $random(seed);
		if (kind[0]) begin
			write_word(addr, data, $sformatf("random_write_%0d", i));
		end else begin
			read_word(addr, $sformatf("random_read_%0d", i));
		end
	end

	finish_last_request();

	repeat (2) @(posedge clk);
	proto_errors = int'(uncached_dbus_top_i.uncached_dbus_assert_i.fail_count);
	$display("Checks %0d, errors %0d, protocol errors %0d, timeouts %0d",
		checks, errors, proto_errors, timeouts);
	if (errors == 0 && proto_errors == 0 && timeouts == 0) begin
		$display("PASS: all tests");
	end else begin
		$display("FAIL: see errors above");
	end
	$finish;
end

endmodule

`default_nettype wire
